/* ahb_apb_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_macros.svh"

module ahb_apb_bridge (
   input  logic                        hclk,
   input  logic                        rst_n,
   input  apb_subsystem_pkg::ahb_req_t ahb_req,
   output apb_subsystem_pkg::ahb_rsp_t ahb_rsp,
   output apb_subsystem_pkg::apb_req_t apb_req,
   output logic                        psel_en,
   input  apb_subsystem_pkg::apb_rsp_t apb_rsp
);

   // FSM state
   apb_subsystem_pkg::bridge_state_e state;
   apb_subsystem_pkg::bridge_state_e state_nxt;

   // Captured transfer
   apb_subsystem_pkg::addr_t addr_q;
   logic                     write_q;
   apb_subsystem_pkg::data_t wdata_q;
   apb_subsystem_pkg::data_t rdata_q;

   // Handshake
   logic hready_int;
   logic accept;
   logic apb_done;

   // --------------------
   // AHB address phase

   // Ready only between transfers and in last error cycle
   assign hready_int = (state == apb_subsystem_pkg::IDLE) ||
                       (state == apb_subsystem_pkg::ERR2);

   // NONSEQ or SEQ with global ready high
   assign accept = hready_int && ahb_req.hsel && ahb_req.htrans[1] &&
                   ahb_req.hready_in;

   // APB access phase finished by the selected slot
   assign apb_done = (state == apb_subsystem_pkg::ACCESS) && apb_rsp.pready;

   // --------------------
   // FSM

   always_comb begin
      state_nxt = state;
      case (state)
         apb_subsystem_pkg::IDLE,
         apb_subsystem_pkg::ERR2: begin
            // New transfer may follow an error directly
            if (accept) begin
               state_nxt = apb_subsystem_pkg::SETUP;
            end else begin
               state_nxt = apb_subsystem_pkg::IDLE;
            end
         end
         apb_subsystem_pkg::SETUP: begin
            state_nxt = apb_subsystem_pkg::ACCESS;
         end
         apb_subsystem_pkg::ACCESS: begin
            // Hold here while slot stalls
            if (apb_rsp.pready) begin
               if (apb_rsp.no_slave) begin
                  state_nxt = apb_subsystem_pkg::ERR1;
               end else begin
                  state_nxt = apb_subsystem_pkg::IDLE;
               end
            end
         end
         apb_subsystem_pkg::ERR1: begin
            state_nxt = apb_subsystem_pkg::ERR2;
         end
         default: begin
            state_nxt = apb_subsystem_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         state <= apb_subsystem_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // --------------------
   // Data path

   always_ff @(posedge hclk) begin
      // Address and direction at acceptance
      if (accept) begin
         addr_q  <= ahb_req.haddr;
         write_q <= ahb_req.hwrite;
      end
      // AHB data phase coincides with SETUP
      if (state == apb_subsystem_pkg::SETUP) begin
         wdata_q <= ahb_req.hwdata;
      end
      // Read data held until hready
      if (apb_done && !apb_rsp.no_slave && !write_q) begin
         rdata_q <= apb_rsp.prdata;
      end
   end

   // APB request
   always_comb begin
      apb_req.paddr   = addr_q;
      apb_req.pwrite  = write_q;
      apb_req.penable = (state == apb_subsystem_pkg::ACCESS);
      // hwdata passes straight through in SETUP, register afterwards
      if (state == apb_subsystem_pkg::SETUP) begin
         apb_req.pwdata = ahb_req.hwdata;
      end else begin
         apb_req.pwdata = wdata_q;
      end
   end

   // Decoder selects only in SETUP and ACCESS
   assign psel_en = (state == apb_subsystem_pkg::SETUP) ||
                    (state == apb_subsystem_pkg::ACCESS);

   // AHB response
   always_comb begin
      ahb_rsp.hrdata = rdata_q;
      ahb_rsp.hready = hready_int;
      if ((state == apb_subsystem_pkg::ERR1) || (state == apb_subsystem_pkg::ERR2)) begin
         ahb_rsp.hresp = `AHB_ERROR;
      end else begin
         ahb_rsp.hresp = `AHB_OKAY;
      end
   end

endmodule

`default_nettype wire

/* alut_table.sv */
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_macros.svh"

module alut_table (
   input  logic                        hclk,
   input  logic                        rst_n,
   input  logic                        psel,
   input  apb_subsystem_pkg::apb_req_t apb_req,
   output apb_subsystem_pkg::data_t    prdata
);

   localparam int IDX_W = $clog2(`ALUT_ENTRIES);
   localparam int CNT_W = $clog2(`ALUT_ENTRIES + 1);

   // APB decode
   logic [`ALUT_OFS_BITS-1:0] ofs;
   logic                      wr_en;
   logic                      cmd_wr;

   // Software visible registers
   apb_subsystem_pkg::data_t     key_lo;
   logic [15:0]                  key_hi;
   apb_subsystem_pkg::port_t     port_reg;
   apb_subsystem_pkg::mac_addr_t key;

   // Table
   logic [`ALUT_ENTRIES-1:0]     ent_valid;
   apb_subsystem_pkg::mac_addr_t ent_mac  [`ALUT_ENTRIES];
   apb_subsystem_pkg::port_t     ent_port [`ALUT_ENTRIES];

   // Search results
   logic             match;
   logic [IDX_W-1:0] match_idx;
   logic             free;
   logic [IDX_W-1:0] free_idx;
   logic [IDX_W-1:0] fill_idx;

   // Replacement, lookup result and count
   logic [IDX_W-1:0]         repl_ptr;
   logic                     lkp_hit;
   apb_subsystem_pkg::port_t lkp_port;
   logic [CNT_W-1:0]         count;

   // pready is tied high, so one ACCESS cycle per write
   assign ofs    = apb_req.paddr[`ALUT_OFS_BITS-1:0];
   assign wr_en  = psel && apb_req.penable && apb_req.pwrite;
   assign cmd_wr = wr_en && (ofs == `ALUT_CMD);
   assign key    = {key_hi, key_lo};

   // --------------------
   // Register writes

   always_ff @(posedge hclk) begin
      if (wr_en && (ofs == `ALUT_KEY_LO)) begin
         key_lo <= apb_req.pwdata;
      end
      if (wr_en && (ofs == `ALUT_KEY_HI)) begin
         key_hi <= apb_req.pwdata[15:0];
      end
      if (wr_en && (ofs == `ALUT_PORT)) begin
         port_reg <= apb_req.pwdata[1:0];
      end
   end

   // --------------------
   // Table search

   always_comb begin
      match     = 1'b0;
      match_idx = '0;
      free      = 1'b0;
      free_idx  = '0;
      for (int i = 0; i < `ALUT_ENTRIES; i++) begin
         if (ent_valid[i] && (ent_mac[i] == key)) begin
            match     = 1'b1;
            match_idx = IDX_W'(i);
         end
      end
      // Downward scan leaves the lowest free entry
      for (int i = `ALUT_ENTRIES - 1; i >= 0; i--) begin
         if (!ent_valid[i]) begin
            free     = 1'b1;
            free_idx = IDX_W'(i);
         end
      end
   end

   // Full table falls back to round robin
   assign fill_idx = free ? free_idx : repl_ptr;

   // Entry contents
   always_ff @(posedge hclk) begin
      if (cmd_wr && (apb_req.pwdata == `ALUT_CMD_LEARN)) begin
         if (match) begin
            // Relearn only moves the port
            ent_port[match_idx] <= port_reg;
         end else begin
            ent_mac[fill_idx]  <= key;
            ent_port[fill_idx] <= port_reg;
         end
      end
   end

   // --------------------
   // Command control

   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         ent_valid <= '0;
         count     <= '0;
         repl_ptr  <= '0;
         lkp_hit   <= 1'b0;
         lkp_port  <= '0;
      end else if (cmd_wr) begin
         case (apb_req.pwdata)
            `ALUT_CMD_LEARN: begin
               if (!match) begin
                  ent_valid[fill_idx] <= 1'b1;
                  if (free) begin
                     count <= count + 1'b1;
                  end else begin
                     // Wraps modulo table depth
                     repl_ptr <= repl_ptr + 1'b1;
                  end
               end
            end
            `ALUT_CMD_LOOKUP: begin
               lkp_hit  <= match;
               lkp_port <= match ? ent_port[match_idx] : '0;
            end
            `ALUT_CMD_CLEAR: begin
               ent_valid <= '0;
               count     <= '0;
               repl_ptr  <= '0;
               lkp_hit   <= 1'b0;
               lkp_port  <= '0;
            end
            default: begin
            end
         endcase
      end
   end

   // --------------------
   // Read mux

   always_comb begin
      case (ofs)
         `ALUT_KEY_LO: prdata = key_lo;
         `ALUT_KEY_HI: prdata = {16'h0, key_hi};
         `ALUT_PORT:   prdata = {30'h0, port_reg};
         // Bit 0 hit, bits 2:1 port
         `ALUT_STATUS: prdata = {29'h0, lkp_port, lkp_hit};
         `ALUT_COUNT:  prdata = {{(32 - CNT_W){1'b0}}, count};
         default:      prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* apb_slave_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_macros.svh"

module apb_slave_decode (
   input  apb_subsystem_pkg::apb_req_t  apb_req,
   input  logic                         psel_en,
   output apb_subsystem_pkg::slot_sel_t psel,
   input  apb_subsystem_pkg::data_t     prdata_slot [`APB_NUM_SLOTS],
   input  apb_subsystem_pkg::slot_sel_t pready_slot,
   output apb_subsystem_pkg::apb_rsp_t  apb_rsp
);

   apb_subsystem_pkg::addr_t     ofs;
   apb_subsystem_pkg::addr_t     slot_num;
   apb_subsystem_pkg::slot_sel_t slot_hit;

   // Offset from slot 0, addresses below the base wrap high and miss
   assign ofs      = apb_req.paddr - `APB_SLOT_BASE;
   assign slot_num = ofs >> `APB_SLOT_SHIFT;

   // One-hot range match
   always_comb begin
      slot_hit = '0;
      for (int i = 0; i < `APB_NUM_SLOTS; i++) begin
         if (slot_num == apb_subsystem_pkg::addr_t'(i)) begin
            slot_hit[i] = 1'b1;
         end
      end
   end

   // Selects only while bridge asks
   assign psel = psel_en ? slot_hit : '0;

   // --------------------
   // Response mux

   always_comb begin
      // Nothing matched, complete at once and flag it
      apb_rsp.prdata   = '0;
      apb_rsp.pready   = 1'b1;
      apb_rsp.no_slave = ~|slot_hit;
      for (int i = 0; i < `APB_NUM_SLOTS; i++) begin
         if (slot_hit[i]) begin
            apb_rsp.prdata = prdata_slot[i];
            apb_rsp.pready = pready_slot[i];
         end
      end
   end

endmodule

`default_nettype wire

/* apb_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_macros.svh"

module apb_subsystem (
   input  logic                        hclk,
   input  logic                        rst_n,
   input  apb_subsystem_pkg::ahb_req_t ahb_req,
   output apb_subsystem_pkg::ahb_rsp_t ahb_rsp,
   output apb_subsystem_pkg::apb_req_t apb_req,
   output logic [3:0]                  psel_mac,
   input  apb_subsystem_pkg::data_t    prdata_mac [4],
   input  logic [3:0]                  pready_mac
);

   logic                         psel_en;
   apb_subsystem_pkg::slot_sel_t psel;
   apb_subsystem_pkg::apb_rsp_t  apb_rsp;
   apb_subsystem_pkg::data_t     prdata_alut;
   apb_subsystem_pkg::data_t     prdata_slot [`APB_NUM_SLOTS];
   apb_subsystem_pkg::slot_sel_t pready_slot;

   // --------------------
   // Slot map
   // Slot 0 ALUT, slots 1 to 4 external MACs
   assign prdata_slot[0] = prdata_alut;
   assign prdata_slot[1] = prdata_mac[0];
   assign prdata_slot[2] = prdata_mac[1];
   assign prdata_slot[3] = prdata_mac[2];
   assign prdata_slot[4] = prdata_mac[3];

   // ALUT never stalls
   assign pready_slot = {pready_mac, 1'b1};
   assign psel_mac    = psel[`APB_NUM_SLOTS-1:1];

   ahb_apb_bridge i_ahb_apb_bridge (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .ahb_req (ahb_req),
      .ahb_rsp (ahb_rsp),
      .apb_req (apb_req),
      .psel_en (psel_en),
      .apb_rsp (apb_rsp)
   );

   apb_slave_decode i_apb_slave_decode (
      .apb_req     (apb_req),
      .psel_en     (psel_en),
      .psel        (psel),
      .prdata_slot (prdata_slot),
      .pready_slot (pready_slot),
      .apb_rsp     (apb_rsp)
   );

   alut_table i_alut_table (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .psel    (psel[0]),
      .apb_req (apb_req),
      .prdata  (prdata_alut)
   );

endmodule

`default_nettype wire

/* apb_subsystem_assert.sv */
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_macros.svh"

module apb_subsystem_assert (
   input logic                         hclk,
   input logic                         rst_n,
   input logic                         psel_en,
   input apb_subsystem_pkg::slot_sel_t psel,
   input apb_subsystem_pkg::apb_req_t  apb_req,
   input apb_subsystem_pkg::apb_rsp_t  apb_rsp,
   input apb_subsystem_pkg::ahb_rsp_t  ahb_rsp
);

   // Failures seen so far, watched by the testbench
   int unsigned fail_count;
   logic        err_rsp;

   initial fail_count = 0;

   assign err_rsp = (ahb_rsp.hresp == `AHB_ERROR);

   // --------------------
   // APB side

   // Never two slots at once
   a_psel_onehot: assert property (@(posedge hclk) disable iff (!rst_n)
      $onehot0(psel))
      else begin
         fail_count++;
         $error("more than one APB slot selected");
      end

   // Select request also covers the no-slave case
   a_penable_after_sel: assert property (@(posedge hclk) disable iff (!rst_n)
      $rose(apb_req.penable) |-> $past(psel_en && !apb_req.penable))
      else begin
         fail_count++;
         $error("penable rose without a setup cycle before it");
      end

   // Address and direction held across wait states
   a_stable_wait: assert property (@(posedge hclk) disable iff (!rst_n)
      (apb_req.penable && !apb_rsp.pready) |=>
         ($stable(apb_req.paddr) && $stable(apb_req.pwrite)))
      else begin
         fail_count++;
         $error("paddr or pwrite changed during a wait state");
      end

   // --------------------
   // AHB side

   // Two-cycle ERROR, hready low first
   a_err_first: assert property (@(posedge hclk) disable iff (!rst_n)
      $rose(err_rsp) |-> !ahb_rsp.hready)
      else begin
         fail_count++;
         $error("ERROR response started with hready high");
      end

   a_err_second: assert property (@(posedge hclk) disable iff (!rst_n)
      (err_rsp && !ahb_rsp.hready) |=> (err_rsp && ahb_rsp.hready))
      else begin
         fail_count++;
         $error("ERROR response not completed in its second cycle");
      end

endmodule

`default_nettype wire

/* apb_subsystem_macros.svh */
`ifndef APB_SUBSYSTEM_MACROS_SVH
`define APB_SUBSYSTEM_MACROS_SVH

// APB slot map
`define APB_SLOT_BASE   32'h00A0_0000
`define APB_SLOT_SHIFT  16
`define APB_NUM_SLOTS   5

// AHB response codes
`define AHB_OKAY        2'b00
`define AHB_ERROR       2'b01

// ALUT geometry
`define ALUT_ENTRIES    8
`define ALUT_OFS_BITS   7

// ALUT register offsets within slot 0
`define ALUT_KEY_LO     7'h00
`define ALUT_KEY_HI     7'h04
`define ALUT_PORT       7'h08
`define ALUT_CMD        7'h0C
`define ALUT_STATUS     7'h10
`define ALUT_COUNT      7'h14

// Values written to ALUT_CMD
`define ALUT_CMD_LEARN  32'd1
`define ALUT_CMD_LOOKUP 32'd2
`define ALUT_CMD_CLEAR  32'd3

`endif

/* apb_subsystem_pkg.sv */
`default_nettype none

`include "apb_subsystem_macros.svh"

package apb_subsystem_pkg;

   // --------------------
   // Bus and table vectors
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [1:0]  htrans_t;
   // OKAY or ERROR only
   typedef logic [1:0]  hresp_t;
   typedef logic [47:0] mac_addr_t;
   typedef logic [1:0]  port_t;
   // One bit per APB slot
   typedef logic [`APB_NUM_SLOTS-1:0] slot_sel_t;

   // Bridge FSM
   typedef enum logic [2:0] {
      IDLE,
      SETUP,
      ACCESS,
      ERR1,
      ERR2
   } bridge_state_e;

   // --------------------
   // AHB-Lite master to subsystem
   typedef struct packed {
      logic    hsel;
      addr_t   haddr;
      htrans_t htrans;
      logic [2:0] hsize;
      logic    hwrite;
      data_t   hwdata;
      logic    hready_in;
   } ahb_req_t;

   // Subsystem back to master
   typedef struct packed {
      data_t  hrdata;
      logic   hready;
      hresp_t hresp;
   } ahb_rsp_t;

   // Shared APB request, selects travel apart
   typedef struct packed {
      addr_t paddr;
      logic  pwrite;
      logic  penable;
      data_t pwdata;
   } apb_req_t;

   // Muxed slot response
   typedef struct packed {
      data_t prdata;
      logic  pready;
      logic  no_slave;
   } apb_rsp_t;

endpackage

`default_nettype wire

/* project.f */
+incdir+.
apb_subsystem_pkg.sv
ahb_apb_bridge.sv
apb_slave_decode.sv
alut_table.sv
apb_subsystem.sv
apb_subsystem_assert.sv
tb_apb_subsystem.sv

/* run.sh */
#!/bin/sh
# Compile and run the APB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_apb_subsystem -Mdir obj_dir

./obj_dir/Vtb_apb_subsystem +verilator+error+limit+100 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tb_apb_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_macros.svh"

module tb_apb_subsystem;

   // About 300 transfers at up to 8 cycles each
   localparam int MAX_CYCLES  = 3000;
   localparam int HANG_CYCLES = 20;

   logic                        hclk;
   logic                        rst_n;
   apb_subsystem_pkg::ahb_req_t ahb_req;
   apb_subsystem_pkg::ahb_rsp_t ahb_rsp;
   apb_subsystem_pkg::apb_req_t apb_req;
   logic [3:0]                  psel_mac;
   apb_subsystem_pkg::data_t    prdata_mac [4];
   logic [3:0]                  pready_mac;

   // MAC slave models and predicted contents
   apb_subsystem_pkg::data_t mac_mem [4][16];
   apb_subsystem_pkg::data_t mac_ref [4][16];
   int                       mac_wait [4];
   logic [3:0]               exp_sel;
   int                       seed;
   int                       cycles;

   // ALUT reference copy
   logic [`ALUT_ENTRIES-1:0]     ref_valid;
   apb_subsystem_pkg::mac_addr_t ref_mac [`ALUT_ENTRIES];
   apb_subsystem_pkg::port_t     ref_port [`ALUT_ENTRIES];
   int                           ref_count;
   int                           ref_ptr;
   apb_subsystem_pkg::data_t     ref_status;

   // Results queued for the compare process
   string                     rsp_name [$];
   apb_subsystem_pkg::hresp_t rsp_exp [$];
   apb_subsystem_pkg::hresp_t rsp_act [$];
   string                     dat_name [$];
   apb_subsystem_pkg::data_t  dat_exp [$];
   apb_subsystem_pkg::data_t  dat_act [$];

   apb_subsystem i_dut (
      .hclk       (hclk),
      .rst_n      (rst_n),
      .ahb_req    (ahb_req),
      .ahb_rsp    (ahb_rsp),
      .apb_req    (apb_req),
      .psel_mac   (psel_mac),
      .prdata_mac (prdata_mac),
      .pready_mac (pready_mac)
   );

   bind apb_subsystem apb_subsystem_assert i_apb_subsystem_assert (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .psel_en (psel_en),
      .psel    (psel),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .ahb_rsp (ahb_rsp)
   );

   initial begin
      hclk = 1'b0;
      forever #50 hclk = ~hclk;
   end

   // --------------------
   // Failure reporting

   task automatic end_with_failure();
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string name, input apb_subsystem_pkg::data_t exp,
                             input apb_subsystem_pkg::data_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h actual %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_resp(input string name, input apb_subsystem_pkg::hresp_t exp,
                             input apb_subsystem_pkg::hresp_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected hresp %h actual %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic compare_select(input string name, input logic [3:0] exp,
                                 input logic [3:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s: expected %b actual %b", name, exp, act);
         end_with_failure();
      end
   endtask

   // --------------------
   // Reference models

   // Applies learn, lookup and clear to the copy and returns STATUS
   function automatic apb_subsystem_pkg::data_t alut_model(
      input apb_subsystem_pkg::data_t cmd, input apb_subsystem_pkg::mac_addr_t key,
      input apb_subsystem_pkg::port_t port);
      int idx;
      idx = -1;
      for (int i = 0; i < `ALUT_ENTRIES; i++) begin
         if (ref_valid[i] && (ref_mac[i] == key)) begin
            idx = i;
         end
      end
      if (cmd == `ALUT_CMD_LEARN) begin
         if (idx >= 0) begin
            ref_port[idx] = port;
         end else begin
            // Lowest free entry before round robin
            for (int i = `ALUT_ENTRIES - 1; i >= 0; i--) begin
               if (!ref_valid[i]) begin
                  idx = i;
               end
            end
            if (idx >= 0) begin
               ref_count++;
            end else begin
               idx     = ref_ptr;
               ref_ptr = (ref_ptr + 1) % `ALUT_ENTRIES;
            end
            ref_valid[idx] = 1'b1;
            ref_mac[idx]   = key;
            ref_port[idx]  = port;
         end
      end else if (cmd == `ALUT_CMD_LOOKUP) begin
         ref_status = (idx >= 0) ? {29'h0, ref_port[idx], 1'b1} : '0;
      end else if (cmd == `ALUT_CMD_CLEAR) begin
         ref_valid  = '0;
         ref_count  = 0;
         ref_ptr    = 0;
         ref_status = '0;
      end
      return ref_status;
   endfunction

   // Anything outside the five slots answers ERROR
   function automatic apb_subsystem_pkg::hresp_t expected_resp(
      input apb_subsystem_pkg::addr_t addr);
      if ((addr >= `APB_SLOT_BASE) &&
          (addr < `APB_SLOT_BASE + (`APB_NUM_SLOTS << `APB_SLOT_SHIFT))) begin
         return `AHB_OKAY;
      end
      return `AHB_ERROR;
   endfunction

   // Register w of MAC port k (0 to 3)
   function automatic apb_subsystem_pkg::addr_t mac_reg_addr(input int k, input int w);
      return `APB_SLOT_BASE + ((k + 1) << `APB_SLOT_SHIFT) + (w << 2);
   endfunction

   function automatic apb_subsystem_pkg::mac_addr_t make_mac(input int i);
      return {16'h0200 + 16'(i), 32'h5EED_0000 + 32'(i * 97)};
   endfunction

   // --------------------
   // AHB master

   task automatic bus_transfer(input string name, input logic wr,
                               input apb_subsystem_pkg::addr_t addr,
                               input apb_subsystem_pkg::data_t wdata,
                               input apb_subsystem_pkg::data_t exp_data);
      int                        waited;
      apb_subsystem_pkg::hresp_t exp_rsp;
      waited  = 0;
      exp_rsp = expected_resp(addr);
      // NONSEQ address phase
      ahb_req.hsel   = 1'b1;
      ahb_req.haddr  = addr;
      ahb_req.htrans = 2'b10;
      ahb_req.hwrite = wr;
      @(posedge hclk);
      #1;
      // Data phase
      ahb_req.hsel   = 1'b0;
      ahb_req.htrans = 2'b00;
      ahb_req.hwdata = wdata;
      while (!ahb_rsp.hready) begin
         if (waited == HANG_CYCLES) begin
            $display("bus hung: hready low for %0d cycles in %s", HANG_CYCLES, name);
            end_with_failure();
         end
         waited++;
         @(posedge hclk);
         #1;
      end
      rsp_name.push_back(name);
      rsp_exp.push_back(exp_rsp);
      rsp_act.push_back(ahb_rsp.hresp);
      // No data on an error
      if (!wr && (exp_rsp == `AHB_OKAY)) begin
         dat_name.push_back(name);
         dat_exp.push_back(exp_data);
         dat_act.push_back(ahb_rsp.hrdata);
      end
   endtask

   task automatic write_reg(input string name, input apb_subsystem_pkg::addr_t addr,
                            input apb_subsystem_pkg::data_t data);
      bus_transfer(name, 1'b1, addr, data, '0);
   endtask

   task automatic read_check(input string name, input apb_subsystem_pkg::addr_t addr,
                             input apb_subsystem_pkg::data_t exp);
      bus_transfer(name, 1'b0, addr, '0, exp);
   endtask

   // Key, port and command writes before the model update
   task automatic issue_command(input string name, input apb_subsystem_pkg::data_t cmd,
                                input apb_subsystem_pkg::mac_addr_t key,
                                input apb_subsystem_pkg::port_t port);
      write_reg({name, " key lo"}, `APB_SLOT_BASE + `ALUT_KEY_LO, key[31:0]);
      write_reg({name, " key hi"}, `APB_SLOT_BASE + `ALUT_KEY_HI, {16'h0, key[47:32]});
      write_reg({name, " port"}, `APB_SLOT_BASE + `ALUT_PORT, {30'h0, port});
      write_reg({name, " cmd"}, `APB_SLOT_BASE + `ALUT_CMD, cmd);
      void'(alut_model(cmd, key, port));
   endtask

   task automatic lookup_check(input string name, input apb_subsystem_pkg::mac_addr_t key);
      issue_command(name, `ALUT_CMD_LOOKUP, key, '0);
      read_check({name, " status"}, `APB_SLOT_BASE + `ALUT_STATUS, ref_status);
   endtask

   task automatic count_check(input string name);
      read_check(name, `APB_SLOT_BASE + `ALUT_COUNT, apb_subsystem_pkg::data_t'(ref_count));
   endtask

   // --------------------
   // MAC slaves with 0 to 3 wait states per access

   always @(posedge hclk) begin
      logic [3:0] idx;
      #1;
      for (int k = 0; k < 4; k++) begin
         pready_mac[k] = 1'b0;
         if (psel_mac[k] && !apb_req.penable) begin
            mac_wait[k] = $random(seed) & 3;
         end else if (psel_mac[k]) begin
            if (mac_wait[k] == 0) begin
               idx = apb_req.paddr[5:2];
               if (apb_req.pwrite) begin
                  mac_mem[k][idx] = apb_req.pwdata;
               end
               prdata_mac[k]  = mac_mem[k][idx];
               pready_mac[k] = 1'b1;
            end else begin
               mac_wait[k]--;
            end
         end
      end
      if (psel_mac != 4'b0) begin
         compare_select("psel_mac", exp_sel, psel_mac);
      end
   end

   // Compare process draining what the master posted
   always @(posedge hclk) begin
      string nm;
      while (rsp_name.size() > 0) begin
         nm = rsp_name.pop_front();
         check_resp(nm, rsp_exp.pop_front(), rsp_act.pop_front());
      end
      while (dat_name.size() > 0) begin
         nm = dat_name.pop_front();
         check_data(nm, dat_exp.pop_front(), dat_act.pop_front());
      end
      if (i_dut.i_apb_subsystem_assert.fail_count != 0) begin
         $display("a protocol assertion on the DUT failed");
         end_with_failure();
      end
   end

   always @(posedge hclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         end_with_failure();
      end
   end

   // --------------------
   // Tests

   initial begin
      int                       k;
      int                       w;
      apb_subsystem_pkg::data_t d;
      seed       = 66;
      cycles     = 0;
      exp_sel    = '0;
      ref_valid  = '0;
      ref_count  = 0;
      ref_ptr    = 0;
      ref_status = '0;
      ahb_req           = '0;
      ahb_req.hsize     = 3'b010;
      ahb_req.hready_in = 1'b1;
      pready_mac        = '0;
      for (k = 0; k < 4; k++) begin
         prdata_mac[k] = '0;
         mac_wait[k]   = 0;
         // Fill from the full register address
         for (w = 0; w < 16; w++) begin
            mac_mem[k][w] = ~mac_reg_addr(k, w);
            mac_ref[k][w] = ~mac_reg_addr(k, w);
         end
      end
      rst_n = 1'b0;
      repeat (2) @(posedge hclk);
      #1;
      rst_n = 1'b1;

      // Empty table after reset
      count_check("reset count");
      read_check("reset status", `APB_SLOT_BASE + `ALUT_STATUS, '0);

      // Learn, lookup, relearn
      for (int i = 0; i < 4; i++) begin
         issue_command($sformatf("learn %0d", i), `ALUT_CMD_LEARN, make_mac(i),
                       apb_subsystem_pkg::port_t'(i));
      end
      count_check("count after learn");
      for (int i = 0; i < 4; i++) begin
         lookup_check($sformatf("lookup %0d", i), make_mac(i));
      end
      lookup_check("lookup unknown", make_mac(99));
      issue_command("relearn 2", `ALUT_CMD_LEARN, make_mac(2), 2'd3);
      count_check("count after relearn");
      lookup_check("lookup relearned", make_mac(2));

      // Overflow into round robin and clear
      issue_command("clear before fill", `ALUT_CMD_CLEAR, '0, '0);
      count_check("count after clear");
      for (int i = 10; i < 20; i++) begin
         issue_command($sformatf("fill %0d", i), `ALUT_CMD_LEARN, make_mac(i),
                       apb_subsystem_pkg::port_t'(i % 4));
      end
      count_check("count when full");
      for (int i = 10; i < 20; i++) begin
         lookup_check($sformatf("full lookup %0d", i), make_mac(i));
      end
      issue_command("clear", `ALUT_CMD_CLEAR, '0, '0);
      count_check("count after final clear");
      for (int i = 10; i < 20; i++) begin
         lookup_check($sformatf("cleared lookup %0d", i), make_mac(i));
      end

      // MAC ports under random back-pressure
      for (int n = 0; n < 80; n++) begin
         k       = $random(seed) & 3;
         w       = $random(seed) & 15;
         exp_sel = 4'b0001 << k;
         if ($random(seed) & 1) begin
            d             = $random(seed);
            mac_ref[k][w] = d;
            write_reg($sformatf("mac%0d write %0d", k + 1, w), mac_reg_addr(k, w), d);
         end else begin
            read_check($sformatf("mac%0d read %0d", k + 1, w), mac_reg_addr(k, w),
                       mac_ref[k][w]);
         end
      end
      exp_sel = '0;

      // Unmapped addresses and recovery
      read_check("unmapped slot read", 32'h00A5_0000, '0);
      write_reg("unmapped slot write", 32'h00A5_0000, 32'h1);
      read_check("below base read", 32'h0000_1000, '0);
      write_reg("below base write", 32'h0000_1000, 32'h2);
      count_check("count after errors");

      repeat (2) @(posedge hclk);
      #1;
      // Assertions in the last cycles before the end
      if (i_dut.i_apb_subsystem_assert.fail_count != 0) begin
         $display("a protocol assertion on the DUT failed");
         end_with_failure();
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
